/* common/rvvi_pkg.sv */
package rvvi_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // core side widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN = 32;
  typedef logic [XLEN-1:0] xlen_t;

  localparam int TOTAL_CSRS = 8;   // watched csrs
  localparam int MAX_CSRS   = 3;   // csr slots per record
  localparam int CSR_IDX_W  = $clog2(TOTAL_CSRS);

  typedef logic [CSR_IDX_W-1:0] csr_idx_t;

  // one reported csr
  typedef struct packed {
    logic     valid;
    csr_idx_t idx;
    xlen_t    value;
  } csr_slot_t;

  // one retired instruction, msb first as sent on the wire
  typedef struct packed {
    xlen_t                      pc;
    logic [31:0]                instr;
    logic                       trap;
    logic [1:0]                 priv_mode;
    logic                       gpr_wen;
    logic [4:0]                 gpr_addr;
    xlen_t                      gpr_value;
    logic                       fpr_wen;
    logic [4:0]                 fpr_addr;
    xlen_t                      fpr_value;
    csr_slot_t [0:MAX_CSRS-1]   csrs;       // slot 0 sits highest
  } rvvi_record_t;

  ////////////////////////////////////////////////////////////////////////////
  // frame layout
  ////////////////////////////////////////////////////////////////////////////

  localparam int RECORD_BITS  = $bits(rvvi_record_t);
  localparam int RECORD_BYTES = (RECORD_BITS + 7) / 8;
  localparam int PAD_BITS     = RECORD_BYTES * 8 - RECORD_BITS;  // zeros below the record

  localparam logic [15:0] FRAME_TAG = 16'h5256;  // 'R' then 'V'
  localparam int FRAME_BYTES = RECORD_BYTES + 2;
  localparam int FRAME_BITS  = FRAME_BYTES * 8;
  localparam int BYTE_CNT_W  = $clog2(FRAME_BYTES);

  ////////////////////////////////////////////////////////////////////////////
  // queue and flow control
  ////////////////////////////////////////////////////////////////////////////

  localparam int FIFO_DEPTH   = 8;
  localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
  localparam int COUNT_W      = $clog2(FIFO_DEPTH + 1);
  localparam int STALL_MARGIN = 2;
  localparam int STALL_LEVEL  = FIFO_DEPTH - STALL_MARGIN;  // stall at this fill

  localparam int CREDIT_MAX = 4;
  localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);

  localparam int PACKET_GAP = 2;  // idle clocks between frames
  localparam int GAP_W      = $clog2(PACKET_GAP + 1);

endpackage

/* trace/trace_capture.sv */
module trace_capture (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instr_valid,
  input  rvvi_pkg::xlen_t        pc,
  input  logic [31:0]            instr,
  input  logic                   trap,
  input  logic [1:0]             priv_mode,
  input  logic                   gpr_wen,
  input  logic [4:0]             gpr_addr,
  input  rvvi_pkg::xlen_t        gpr_value,
  input  logic                   fpr_wen,
  input  logic [4:0]             fpr_addr,
  input  rvvi_pkg::xlen_t        fpr_value,
  input  rvvi_pkg::xlen_t        csr_values [rvvi_pkg::TOTAL_CSRS],
  output logic                   push,
  output rvvi_pkg::rvvi_record_t push_record
);

  // last reported value of each watched csr
  rvvi_pkg::xlen_t                        shadow [rvvi_pkg::TOTAL_CSRS];

  rvvi_pkg::csr_slot_t [0:rvvi_pkg::MAX_CSRS-1] slots;
  logic [rvvi_pkg::TOTAL_CSRS-1:0]        take;       // csrs reported this time
  rvvi_pkg::rvvi_record_t                 record_next;

  ////////////////////////////////////////////////////////////////////////////
  // changed csr selection
  ////////////////////////////////////////////////////////////////////////////

  // walk up from index 0, fill slots in order until they run out
  always_comb begin
    int n;
    n     = 0;
    slots = '0;
    take  = '0;
    for (int i = 0; i < rvvi_pkg::TOTAL_CSRS; i++) begin
      if ((csr_values[i] != shadow[i]) && (n < rvvi_pkg::MAX_CSRS)) begin
        slots[n].valid = 1'b1;
        slots[n].idx   = rvvi_pkg::csr_idx_t'(i);
        slots[n].value = csr_values[i];
        take[i]        = 1'b1;
        n              = n + 1;
      end
    end
  end

  always_comb begin
    record_next.pc        = pc;
    record_next.instr     = instr;
    record_next.trap      = trap;
    record_next.priv_mode = priv_mode;
    record_next.gpr_wen   = gpr_wen;
    record_next.gpr_addr  = gpr_addr;
    record_next.gpr_value = gpr_value;
    record_next.fpr_wen   = fpr_wen;
    record_next.fpr_addr  = fpr_addr;
    record_next.fpr_value = fpr_value;
    record_next.csrs      = slots;  // unused slots stay zero
  end

  ////////////////////////////////////////////////////////////////////////////
  // retire register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      push <= 1'b0;
    end else begin
      push <= instr_valid;  // one cycle after retirement
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      push_record <= record_next;
    end
  end

  // only the reported csrs move their shadow, the rest wait for the next retire
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rvvi_pkg::TOTAL_CSRS; i++) begin
        shadow[i] <= '0;
      end
    end else if (instr_valid) begin
      for (int i = 0; i < rvvi_pkg::TOTAL_CSRS; i++) begin
        if (take[i]) begin
          shadow[i] <= csr_values[i];
        end
      end
    end
  end

endmodule

/* trace/trace_fifo.sv */
module trace_fifo (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          push,
  input  rvvi_pkg::rvvi_record_t        push_record,
  input  logic                          pop,
  output rvvi_pkg::rvvi_record_t        head_record,
  output logic [rvvi_pkg::COUNT_W-1:0]  count
);

  rvvi_pkg::rvvi_record_t               mem [rvvi_pkg::FIFO_DEPTH];
  logic [rvvi_pkg::FIFO_PTR_W-1:0]      wr_ptr;
  logic [rvvi_pkg::FIFO_PTR_W-1:0]      rd_ptr;
  logic                                 wr_en;
  logic                                 rd_en;

  // guard against over and underflow even though the stall should prevent it
  assign wr_en = push && (count != rvvi_pkg::COUNT_W'(rvvi_pkg::FIFO_DEPTH));
  assign rd_en = pop && (count != '0);

  assign head_record = mem[rd_ptr];  // head is always visible

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_record;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

/* src/trace_ctrl.sv */
module trace_ctrl (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [rvvi_pkg::COUNT_W-1:0]  count,
  input  logic                          credit_return,
  input  logic                          frame_done,
  output logic                          pop,
  output logic                          frame_start,
  output logic                          external_stall
);

  logic [rvvi_pkg::CREDIT_W-1:0]  credits;
  logic                           busy;      // a frame is on the wire
  logic [rvvi_pkg::GAP_W-1:0]     gap_cnt;   // idle clocks since last frame_done
  logic                           gap_ok;
  logic                           credit_full;

  ////////////////////////////////////////////////////////////////////////////
  // start decision
  ////////////////////////////////////////////////////////////////////////////

  assign gap_ok      = (gap_cnt == rvvi_pkg::GAP_W'(rvvi_pkg::PACKET_GAP));
  assign credit_full = (credits == rvvi_pkg::CREDIT_W'(rvvi_pkg::CREDIT_MAX));

  assign frame_start = (count != '0) && (credits != '0) && !busy && gap_ok;
  assign pop         = frame_start;  // head leaves as the serializer loads it

  // hold the core back before the queue can overflow
  assign external_stall = (count >= rvvi_pkg::COUNT_W'(rvvi_pkg::STALL_LEVEL));

  ////////////////////////////////////////////////////////////////////////////
  // credits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= '0;
    end else begin
      case ({frame_start, credit_return})
        2'b01: begin
          if (!credit_full) begin
            credits <= credits + 1'b1;  // excess returns dropped
          end
        end
        2'b10:   credits <= credits - 1'b1;
        default: credits <= credits;  // start and return cancel
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // frame tracking and inter frame gap
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (frame_start) begin
      busy <= 1'b1;
    end else if (frame_done) begin
      busy <= 1'b0;
    end
  end

  // starts satisfied so the first frame is not delayed
  always_ff @(posedge clk) begin
    if (reset) begin
      gap_cnt <= rvvi_pkg::GAP_W'(rvvi_pkg::PACKET_GAP);
    end else if (frame_done) begin
      gap_cnt <= '0;
    end else if (!busy && !gap_ok) begin
      gap_cnt <= gap_cnt + 1'b1;
    end
  end

endmodule

/* src/frame_serializer.sv */
module frame_serializer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    frame_start,
  input  rvvi_pkg::rvvi_record_t  head_record,
  output logic [7:0]              txd,
  output logic                    tx_en,
  output logic                    frame_done
);

  logic [rvvi_pkg::FRAME_BITS-1:0]  frame_init;
  logic [rvvi_pkg::FRAME_BITS-1:0]  shift_q;    // bytes still to send, msb first
  logic [rvvi_pkg::BYTE_CNT_W-1:0]  remaining;  // bytes left after the one on txd

  // tag on top, record below, zero padding in the low bits
  assign frame_init = rvvi_pkg::FRAME_BITS'({rvvi_pkg::FRAME_TAG, head_record})
                      << rvvi_pkg::PAD_BITS;

  ////////////////////////////////////////////////////////////////////////////
  // byte shifter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (frame_start) begin
      shift_q <= frame_init << 8;  // first byte goes straight to txd
    end else if (tx_en) begin
      shift_q <= shift_q << 8;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_en      <= 1'b0;
      txd        <= 8'h00;
      frame_done <= 1'b0;
      remaining  <= '0;
    end else if (frame_start) begin
      tx_en      <= 1'b1;
      txd        <= frame_init[rvvi_pkg::FRAME_BITS-1 -: 8];
      frame_done <= 1'b0;
      remaining  <= rvvi_pkg::BYTE_CNT_W'(rvvi_pkg::FRAME_BYTES - 1);
    end else if (tx_en) begin
      if (remaining != '0) begin
        txd        <= shift_q[rvvi_pkg::FRAME_BITS-1 -: 8];
        remaining  <= remaining - 1'b1;
        frame_done <= (remaining == rvvi_pkg::BYTE_CNT_W'(1));  // marks the last byte
      end else begin
        // frame finished, back to idle
        tx_en      <= 1'b0;
        txd        <= 8'h00;
        frame_done <= 1'b0;
      end
    end
  end

endmodule

/* src/rvvi_trace_top.sv */
module rvvi_trace_top (
  input  logic                                clk,
  input  logic                                reset,
  // retirement port from the core
  input  logic                                instr_valid,
  input  rvvi_pkg::xlen_t                     pc,
  input  logic [31:0]                         instr,
  input  logic                                trap,
  input  logic [1:0]                          priv_mode,
  input  logic                                gpr_wen,
  input  logic [4:0]                          gpr_addr,
  input  rvvi_pkg::xlen_t                     gpr_value,
  input  logic                                fpr_wen,
  input  logic [4:0]                          fpr_addr,
  input  rvvi_pkg::xlen_t                     fpr_value,
  input  rvvi_pkg::xlen_t                     csr_values [rvvi_pkg::TOTAL_CSRS],
  // host side
  input  logic                                credit_return,
  output logic                                external_stall,
  output logic [7:0]                          txd,
  output logic                                tx_en
);

  logic                            push;
  rvvi_pkg::rvvi_record_t          push_record;
  rvvi_pkg::rvvi_record_t          head_record;
  logic [rvvi_pkg::COUNT_W-1:0]    count;
  logic                            pop;
  logic                            frame_start;
  logic                            frame_done;

  trace_capture u_capture (
    .clk, .reset,
    .instr_valid, .pc, .instr, .trap, .priv_mode,
    .gpr_wen, .gpr_addr, .gpr_value,
    .fpr_wen, .fpr_addr, .fpr_value,
    .csr_values,
    .push, .push_record
  );

  trace_fifo u_fifo (
    .clk, .reset,
    .push, .push_record,
    .pop,
    .head_record, .count
  );

  trace_ctrl u_ctrl (
    .clk, .reset,
    .count, .credit_return, .frame_done,
    .pop, .frame_start, .external_stall
  );

  frame_serializer u_serializer (
    .clk, .reset,
    .frame_start, .head_record,
    .txd, .tx_en, .frame_done
  );

endmodule

/* verif/tb_rvvi_trace.sv */
module tb_rvvi_trace;
  timeunit 1ns;
  timeprecision 1ps;

  // record laid out field by field, a csr slot is valid, 3 bit index, value
  localparam int REC_W    = 2 * 32 + 3 + 2 * (6 + 32) + rvvi_pkg::MAX_CSRS * (4 + 32);
  localparam int FRAME_W  = rvvi_pkg::FRAME_BYTES * 8;
  localparam int PAD_W    = FRAME_W - 16 - REC_W;
  localparam int STALL_AT = rvvi_pkg::FIFO_DEPTH - rvvi_pkg::STALL_MARGIN;

  logic            clk = 1'b0;
  logic            reset;
  logic            instr_valid;
  rvvi_pkg::xlen_t pc;
  logic [31:0]     instr;
  logic            trap;
  logic [1:0]      priv_mode;
  logic            gpr_wen;
  logic [4:0]      gpr_addr;
  rvvi_pkg::xlen_t gpr_value;
  logic            fpr_wen;
  logic [4:0]      fpr_addr;
  rvvi_pkg::xlen_t fpr_value;
  rvvi_pkg::xlen_t csr_values [rvvi_pkg::TOTAL_CSRS];
  logic            credit_return;
  logic            external_stall;
  logic [7:0]      txd;
  logic            tx_en;

  logic [31:0]        lfsr = 32'h8bac2a05;
  rvvi_pkg::xlen_t    csr_drv [rvvi_pkg::TOTAL_CSRS];   // what the core presents
  rvvi_pkg::xlen_t    shadow_m [rvvi_pkg::TOTAL_CSRS];  // last reported value per csr
  logic [FRAME_W-1:0] exp_q [$];                        // expected frames, oldest first
  logic [7:0]         rx_bytes [$];
  int                 frames_rx = 0;
  int                 idle_cnt = 100;

  rvvi_trace_top UUT (.*);

  always #5 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(int nbits);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic fail(string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
    if (actual !== expected) begin
      fail($sformatf("MISMATCH %s: actual 0x%0h expected 0x%0h", name, actual, expected));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model and stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_retire(input logic [31:0] pc_v, input logic [31:0] instr_v,
                              input logic trap_v, input logic [1:0] priv_v,
                              input logic [37:0] gpr_w, input logic [37:0] fpr_w);
    logic [35:0]      slot [3];
    logic [REC_W-1:0] rec;
    int               used;
    used = 0;
    for (int s = 0; s < 3; s++) begin
      slot[s] = '0;
    end
    // lowest changed indices win a slot, leftovers go out with a later retirement
    for (int i = 0; i < rvvi_pkg::TOTAL_CSRS; i++) begin
      if (used < rvvi_pkg::MAX_CSRS && csr_drv[i] != shadow_m[i]) begin
        slot[used]  = {1'b1, 3'(i), csr_drv[i]};
        shadow_m[i] = csr_drv[i];
        used++;
      end
    end
    rec = {pc_v, instr_v, trap_v, priv_v, gpr_w, fpr_w, slot[0], slot[1], slot[2]};
    exp_q.push_back({8'h52, 8'h56, rec, {PAD_W{1'b0}}});
    instr_valid <= 1'b1;
    pc          <= pc_v;
    instr       <= instr_v;
    trap        <= trap_v;
    priv_mode   <= priv_v;
    {gpr_wen, gpr_addr, gpr_value} <= gpr_w;
    {fpr_wen, fpr_addr, fpr_value} <= fpr_w;
    for (int i = 0; i < rvvi_pkg::TOTAL_CSRS; i++) begin
      csr_values[i] <= csr_drv[i];
    end
  endtask

  task automatic retire_random();
    logic [31:0] pc_v;
    logic [31:0] instr_v;
    logic [37:0] gw;
    logic [37:0] fw;
    for (int i = 0; i < rvvi_pkg::TOTAL_CSRS; i++) begin
      if (rand_bits(2) == 32'd0) begin
        csr_drv[i] = rand_bits(32);  // roughly one csr in four moves
      end
    end
    pc_v    = rand_bits(32);
    instr_v = rand_bits(32);
    gw      = {6'(rand_bits(6)), rand_bits(32)};
    fw      = {6'(rand_bits(6)), rand_bits(32)};
    drive_retire(pc_v, instr_v, 1'(rand_bits(1)), 2'(rand_bits(2)), gw, fw);
  endtask

  task automatic end_retire();
    @(posedge clk);
    instr_valid <= 1'b0;
  endtask

  task automatic wait_stall_low(int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (external_stall !== 1'b0) begin
      n++;
      if (n > limit) begin
        fail("timeout: external_stall never dropped so no instruction could retire");
      end
      @(negedge clk);
    end
  endtask

  task automatic retire_one_random();
    wait_stall_low(300);
    @(posedge clk);
    retire_random();
    end_retire();
  endtask

  task automatic give_credits(int n);
    repeat (n) begin
      @(posedge clk);
      credit_return <= 1'b1;
      @(posedge clk);
      credit_return <= 1'b0;
    end
  endtask

  task automatic wait_frames(int target, int limit);
    int n;
    n = 0;
    while (frames_rx < target) begin
      @(posedge clk);
      n++;
      if (n > limit) begin
        fail($sformatf("timeout: only %0d of %0d frames arrived", frames_rx, target));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // frame monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_frame();
    logic [FRAME_W-1:0] want;
    check_value("frame length", rx_bytes.size(), rvvi_pkg::FRAME_BYTES);
    if (exp_q.size() == 0) begin
      fail("a frame arrived with no retired instruction left to match it");
    end
    want = exp_q.pop_front();
    for (int i = 0; i < rvvi_pkg::FRAME_BYTES; i++) begin
      check_value($sformatf("txd byte %0d of frame %0d", i, frames_rx),
                  rx_bytes[i], want[FRAME_W-1-8*i -: 8]);  // msb first
    end
    rx_bytes.delete();
    frames_rx++;
  endtask

  // sampled mid cycle, away from the edge that moves tx_en and txd
  always @(negedge clk) begin
    if (tx_en === 1'b1) begin
      if (rx_bytes.size() == 0 && idle_cnt < rvvi_pkg::PACKET_GAP) begin
        fail($sformatf("frame %0d started after only %0d idle cycles", frames_rx, idle_cnt));
      end
      rx_bytes.push_back(txd);
    end else begin
      check_value("txd", txd, 8'h00);
      if (rx_bytes.size() != 0) begin
        check_frame();
        idle_cnt = 1;
      end else begin
        idle_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_state_check();
    @(negedge clk);
    check_value("tx_en", tx_en, 0);
    check_value("txd", txd, 0);
    check_value("external_stall", external_stall, 0);
    repeat (2) retire_one_random();
    repeat (50) begin
      @(negedge clk);
      check_value("tx_en", tx_en, 0);  // no credit yet
    end
    give_credits(2);
    wait_frames(2, 300);
  endtask

  task automatic single_frame();
    int base;
    base = frames_rx;
    wait_stall_low(50);
    @(posedge clk);
    drive_retire(rand_bits(32), rand_bits(32), 1'b0, 2'b11,
                 {1'b1, 5'(rand_bits(5)), rand_bits(32)}, 38'h0);
    end_retire();
    give_credits(1);
    wait_frames(base + 1, 200);
    repeat (60) @(posedge clk);
    check_value("frames received", frames_rx, base + 1);
  endtask

  task automatic csr_reporting();
    int changed [5] = '{1, 2, 4, 6, 7};
    int base;
    base = frames_rx;
    foreach (changed[k]) begin
      csr_drv[changed[k]] = csr_drv[changed[k]] ^ (rand_bits(32) | 32'h1);
    end
    retire_one_random_fields();
    csr_drv[3] = shadow_m[3];  // rewritten with the value it already holds
    retire_one_random_fields();
    give_credits(2);
    wait_frames(base + 2, 300);
  endtask

  // random fields but csrs left as the test set them
  task automatic retire_one_random_fields();
    wait_stall_low(50);
    @(posedge clk);
    drive_retire(rand_bits(32), rand_bits(32), 1'b0, 2'b01,
                 {1'b1, 5'(rand_bits(5)), rand_bits(32)},
                 {1'b1, 5'(rand_bits(5)), rand_bits(32)});
    end_retire();
  endtask

  task automatic credit_flow();
    int burst [4] = '{3, 3, 4, 0};
    int grant [4] = '{2, 3, 4, 1};
    int base;
    for (int r = 0; r < 4; r++) begin
      repeat (burst[r]) retire_one_random();
      base = frames_rx;
      give_credits(grant[r]);
      wait_frames(base + grant[r], 400);
      repeat (60) @(posedge clk);
      check_value("frames received", frames_rx, base + grant[r]);
    end
  endtask

  task automatic back_pressure();
    int         n;
    int         in_q;
    int         base;
    logic [1:0] hist;  // retired at the last two edges, not yet counted
    logic       go;
    logic       saw_stall;
    n         = 0;
    hist      = 2'b00;
    saw_stall = 1'b0;
    for (int c = 0; c < 30; c++) begin
      @(negedge clk);
      in_q = n - hist[0] - hist[1];
      check_value("external_stall", external_stall, in_q >= STALL_AT);
      saw_stall = saw_stall | external_stall;
      go        = !external_stall;
      @(posedge clk);
      if (go) begin
        retire_random();
        n++;
      end else begin
        instr_valid <= 1'b0;
      end
      hist = {hist[0], go};
    end
    end_retire();
    if (!saw_stall) begin
      fail("external_stall never rose while the queue filled");
    end
    for (int i = 0; i < n; i++) begin
      base = frames_rx;
      give_credits(1);
      wait_frames(base + 1, 200);
      @(negedge clk);
      check_value("external_stall", external_stall, (n - i - 1) >= STALL_AT);
    end
  endtask

  initial begin
    reset         = 1'b1;
    instr_valid   = 1'b0;
    pc            = '0;
    instr         = '0;
    trap          = 1'b0;
    priv_mode     = 2'b00;
    gpr_wen       = 1'b0;
    gpr_addr      = '0;
    gpr_value     = '0;
    fpr_wen       = 1'b0;
    fpr_addr      = '0;
    fpr_value     = '0;
    credit_return = 1'b0;
    for (int i = 0; i < rvvi_pkg::TOTAL_CSRS; i++) begin
      csr_values[i] = '0;
      csr_drv[i]    = '0;
      shadow_m[i]   = '0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    reset_state_check();
    single_frame();
    csr_reporting();
    credit_flow();
    back_pressure();

    repeat (20) @(posedge clk);
    if (exp_q.size() != 0) begin
      fail($sformatf("%0d expected frames never arrived", exp_q.size()));
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

/* rvvi_trace.f */
common/rvvi_pkg.sv
trace/trace_capture.sv
trace/trace_fifo.sv
src/trace_ctrl.sv
src/frame_serializer.sv
src/rvvi_trace_top.sv
verif/tb_rvvi_trace.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the trace unit testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rvvi_trace \
  -f rvvi_trace.f -o tb_rvvi_trace > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_rvvi_trace > sim.log 2>&1
cat sim.log

grep -q "Test failures found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation passed"
